//--- Bender.yml
package:
  name: trace_unit

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/trace_pkg.sv
      - hdl/trace_fetch_capture.sv
      - hdl/trace_lsu_capture.sv
      - hdl/trace_record_assembler.sv
      - hdl/trace_stats.sv
      - hdl/trace_unit.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/trace_unit_props.sv
      - tb/trace_unit_tb.sv

//--- hdl/trace_defs.svh
// widths shared by the trace unit RTL and its testbench
// include this file wherever a trace width is needed

`ifndef TRACE_DEFS_SVH
`define TRACE_DEFS_SVH

////////////////////
// ISA widths
////////////////////

// address and data width of RV32
`define TRACE_XLEN 32

// GPR index width, 32 registers
`define TRACE_GLOG 5

////////////////////
// statistics
////////////////////

// counter width, counters saturate at all ones
`define TRACE_CNT_W 16

`endif

//--- hdl/trace_fetch_capture.sv
// fetch bus monitor of the trace unit
// pairs each fetch address with its response word and gives a one-cycle strobe

`timescale 1ns/1ns
`default_nettype none
`include "trace_defs.svh"

module trace_fetch_capture (
  input  wire logic                   tcb_ifu,
  input  wire logic                   reset,
  // fetch bus
  input  wire logic                   ifu_vld,
  input  wire logic                   ifu_rdy,
  input  wire logic [`TRACE_XLEN-1:0] ifu_adr,
  input  wire logic [`TRACE_XLEN-1:0] ifu_rdt,
  // fetched instruction
  output logic                        fet_vld,
  output logic      [`TRACE_XLEN-1:0] fet_pc,
  output logic      [`TRACE_XLEN-1:0] fet_ins,
  output logic                        fet_rvc
);

  // response is expected in the cycle after a transfer
  logic                   req_pend;
  logic [`TRACE_XLEN-1:0] req_adr;
  // compressed when the two low bits are not both set
  logic                   rdt_rvc;

  ////////////////////
  // request stage
  ////////////////////

  always_ff @(posedge tcb_ifu) begin
    if (reset) begin
      req_pend <= 1'b0;
    end else begin
      req_pend <= ifu_vld & ifu_rdy;
    end
  end

  // address follows the request into the response cycle
  always_ff @(posedge tcb_ifu) begin
    if (ifu_vld && ifu_rdy) begin
      req_adr <= ifu_adr;
    end
  end

  ////////////////////
  // response stage
  ////////////////////

  assign rdt_rvc = (ifu_rdt[1:0] != 2'b11);

  always_ff @(posedge tcb_ifu) begin
    if (reset) begin
      fet_vld <= 1'b0;
    end else begin
      fet_vld <= req_pend;
    end
  end

  // upper half of a 16-bit instruction is cleared
  always_ff @(posedge tcb_ifu) begin
    if (req_pend) begin
      fet_pc  <= req_adr;
      fet_rvc <= rdt_rvc;
      fet_ins <= rdt_rvc ? {{(`TRACE_XLEN-16){1'b0}}, ifu_rdt[15:0]} : ifu_rdt;
    end
  end

endmodule: trace_fetch_capture

`default_nettype wire

//--- hdl/trace_lsu_capture.sv
// load/store bus monitor of the trace unit
// pairs each request with its load response or store data and classifies it

`timescale 1ns/1ns
`default_nettype none
`include "trace_defs.svh"

module trace_lsu_capture (
  input  wire logic                   tcb_ifu,
  input  wire logic                   reset,
  // load/store bus
  input  wire logic                   lsu_vld,
  input  wire logic                   lsu_rdy,
  input  wire logic                   lsu_wen,
  input  wire logic [`TRACE_XLEN-1:0] lsu_adr,
  input  wire logic [`TRACE_XLEN-1:0] lsu_wdt,
  input  wire logic [`TRACE_XLEN-1:0] lsu_rdt,
  // memory event
  output logic                        mem_vld,
  output trace_pkg::mem_kind_t        mem_kind,
  output logic      [`TRACE_XLEN-1:0] mem_adr,
  output logic      [`TRACE_XLEN-1:0] mem_dat
);

  import trace_pkg::*;

  // request kept across the response cycle
  logic                   req_pend;
  logic                   req_wen;
  logic [`TRACE_XLEN-1:0] req_adr;
  logic [`TRACE_XLEN-1:0] req_wdt;

  ////////////////////
  // request stage
  ////////////////////

  always_ff @(posedge tcb_ifu) begin
    if (reset) begin
      req_pend <= 1'b0;
    end else begin
      req_pend <= lsu_vld & lsu_rdy;
    end
  end

  always_ff @(posedge tcb_ifu) begin
    if (lsu_vld && lsu_rdy) begin
      req_wen <= lsu_wen;
      req_adr <= lsu_adr;
      req_wdt <= lsu_wdt;
    end
  end

  ////////////////////
  // response stage
  ////////////////////

  // kind reads mem_none between events
  always_ff @(posedge tcb_ifu) begin
    if (reset) begin
      mem_vld  <= 1'b0;
      mem_kind <= mem_none;
    end else begin
      mem_vld  <= req_pend;
      mem_kind <= !req_pend ? mem_none : (req_wen ? mem_store : mem_load);
    end
  end

  // store data from the request, load data from the response
  always_ff @(posedge tcb_ifu) begin
    if (req_pend) begin
      mem_adr <= req_adr;
      mem_dat <= req_wen ? req_wdt : lsu_rdt;
    end
  end

endmodule: trace_lsu_capture

`default_nettype wire

//--- hdl/trace_pkg.sv
// enum types of the trace unit
// used by the capture blocks, the assembler, the statistics and the testbench

`default_nettype none

package trace_pkg;

  ////////////////////
  // memory access
  ////////////////////

  // memory access attached to a trace record
  typedef enum logic [1:0] {
    mem_none  = 2'd0,
    mem_load  = 2'd1,
    mem_store = 2'd2
  } mem_kind_t;

  ////////////////////
  // assembler FSM
  ////////////////////

  // idle until the first instruction has been fetched
  typedef enum logic {
    asm_idle   = 1'b0,
    asm_active = 1'b1
  } asm_state_t;

endpackage: trace_pkg

`default_nettype wire

//--- hdl/trace_record_assembler.sv
// builds one trace record per committed instruction
// the record of an instruction leaves one cycle after the next fetch strobe

`timescale 1ns/1ns
`default_nettype none
`include "trace_defs.svh"

module trace_record_assembler (
  input  wire logic                   tcb_ifu,
  input  wire logic                   reset,
  // fetched instruction
  input  wire logic                   fet_vld,
  input  wire logic [`TRACE_XLEN-1:0] fet_pc,
  input  wire logic [`TRACE_XLEN-1:0] fet_ins,
  input  wire logic                   fet_rvc,
  // memory event
  input  wire logic                   mem_vld,
  input  wire trace_pkg::mem_kind_t   mem_kind,
  input  wire logic [`TRACE_XLEN-1:0] mem_adr,
  input  wire logic [`TRACE_XLEN-1:0] mem_dat,
  // GPR write port
  input  wire logic                   gpr_wen,
  input  wire logic [`TRACE_GLOG-1:0] gpr_wid,
  input  wire logic [`TRACE_XLEN-1:0] gpr_wdt,
  // trace record
  output logic                        trace_vld,
  output logic      [`TRACE_XLEN-1:0] trace_pc,
  output logic      [`TRACE_XLEN-1:0] trace_ins,
  output logic                        trace_rvc,
  output logic                        trace_gpr_vld,
  output logic      [`TRACE_GLOG-1:0] trace_gpr_idx,
  output logic      [`TRACE_XLEN-1:0] trace_gpr_dat,
  output trace_pkg::mem_kind_t        trace_mem,
  output logic      [`TRACE_XLEN-1:0] trace_mem_adr,
  output logic      [`TRACE_XLEN-1:0] trace_mem_dat
);

  import trace_pkg::*;

  asm_state_t state;

  // current instruction
  logic [`TRACE_XLEN-1:0] cur_pc;
  logic [`TRACE_XLEN-1:0] cur_ins;
  logic                   cur_rvc;

  // last GPR write and memory event of the current instruction
  logic                   acc_gpr_vld;
  logic [`TRACE_GLOG-1:0] acc_gpr_idx;
  logic [`TRACE_XLEN-1:0] acc_gpr_dat;
  mem_kind_t              acc_mem;
  logic [`TRACE_XLEN-1:0] acc_mem_adr;
  logic [`TRACE_XLEN-1:0] acc_mem_dat;

  logic gpr_evt;
  logic rec_fire;

  // x0 writes never reach the trace
  assign gpr_evt  = gpr_wen && (gpr_wid != '0);
  // no record for the first fetch after reset
  assign rec_fire = fet_vld && (state == asm_active);

  ////////////////////
  // FSM
  ////////////////////

  always_ff @(posedge tcb_ifu) begin
    if (reset) begin
      state <= asm_idle;
    end else if (fet_vld) begin
      state <= asm_active;
    end
  end

  always_ff @(posedge tcb_ifu) begin
    if (fet_vld) begin
      cur_pc  <= fet_pc;
      cur_ins <= fet_ins;
      cur_rvc <= fet_rvc;
    end
  end

  ////////////////////
  // accumulators
  ////////////////////

  // a new fetch clears both, events with it went to the outgoing record
  always_ff @(posedge tcb_ifu) begin
    if (reset) begin
      acc_gpr_vld <= 1'b0;
      acc_mem     <= mem_none;
    end else if (fet_vld) begin
      acc_gpr_vld <= 1'b0;
      acc_mem     <= mem_none;
    end else begin
      if (gpr_evt) begin
        acc_gpr_vld <= 1'b1;
      end
      if (mem_vld) begin
        acc_mem <= mem_kind;
      end
    end
  end

  // a later event replaces an earlier one
  always_ff @(posedge tcb_ifu) begin
    if (gpr_evt) begin
      acc_gpr_idx <= gpr_wid;
      acc_gpr_dat <= gpr_wdt;
    end
    if (mem_vld) begin
      acc_mem_adr <= mem_adr;
      acc_mem_dat <= mem_dat;
    end
  end

  ////////////////////
  // record output
  ////////////////////

  // events in the fetch cycle take priority over the accumulated ones
  always_ff @(posedge tcb_ifu) begin
    if (reset) begin
      trace_vld     <= 1'b0;
      trace_gpr_vld <= 1'b0;
      trace_mem     <= mem_none;
    end else begin
      trace_vld <= rec_fire;
      if (rec_fire) begin
        trace_gpr_vld <= gpr_evt | acc_gpr_vld;
        trace_mem     <= mem_vld ? mem_kind : acc_mem;
      end
    end
  end

  always_ff @(posedge tcb_ifu) begin
    if (rec_fire) begin
      trace_pc      <= cur_pc;
      trace_ins     <= cur_ins;
      trace_rvc     <= cur_rvc;
      trace_gpr_idx <= gpr_evt ? gpr_wid : acc_gpr_idx;
      trace_gpr_dat <= gpr_evt ? gpr_wdt : acc_gpr_dat;
      trace_mem_adr <= mem_vld ? mem_adr : acc_mem_adr;
      trace_mem_dat <= mem_vld ? mem_dat : acc_mem_dat;
    end
  end

endmodule: trace_record_assembler

`default_nettype wire

//--- hdl/trace_stats.sv
// running statistics of the trace stream
// counts retired, load, store and compressed instructions, stopping at all ones

`timescale 1ns/1ns
`default_nettype none
`include "trace_defs.svh"

module trace_stats (
  input  wire logic                    tcb_ifu,
  input  wire logic                    reset,
  // trace record fields
  input  wire logic                    trace_vld,
  input  wire trace_pkg::mem_kind_t    trace_mem,
  input  wire logic                    trace_rvc,
  // counters
  output logic      [`TRACE_CNT_W-1:0] cnt_ret,
  output logic      [`TRACE_CNT_W-1:0] cnt_ld,
  output logic      [`TRACE_CNT_W-1:0] cnt_st,
  output logic      [`TRACE_CNT_W-1:0] cnt_rvc
);

  import trace_pkg::*;

  // increment unless already saturated
  function automatic logic [`TRACE_CNT_W-1:0] sat_inc(
    input logic [`TRACE_CNT_W-1:0] cnt,
    input logic                    en
  );
    if (en && !(&cnt)) begin
      return cnt + 1'b1;
    end
    return cnt;
  endfunction: sat_inc

  ////////////////////
  // counters
  ////////////////////

  // every field is taken from the record of the same cycle
  always_ff @(posedge tcb_ifu) begin
    if (reset) begin
      cnt_ret <= '0;
      cnt_ld  <= '0;
      cnt_st  <= '0;
      cnt_rvc <= '0;
    end else if (trace_vld) begin
      cnt_ret <= sat_inc(cnt_ret, 1'b1);
      cnt_ld  <= sat_inc(cnt_ld, trace_mem == mem_load);
      cnt_st  <= sat_inc(cnt_st, trace_mem == mem_store);
      cnt_rvc <= sat_inc(cnt_rvc, trace_rvc);
    end
  end

endmodule: trace_stats

`default_nettype wire

//--- hdl/trace_unit.sv
// execution trace unit top level
// monitors fetch, load/store and GPR write ports and emits one record per instruction

`timescale 1ns/1ns
`default_nettype none
`include "trace_defs.svh"

module trace_unit (
  input  wire logic                    tcb_ifu,
  input  wire logic                    reset,
  // fetch bus
  input  wire logic                    ifu_vld,
  input  wire logic                    ifu_rdy,
  input  wire logic [`TRACE_XLEN-1:0]  ifu_adr,
  input  wire logic [`TRACE_XLEN-1:0]  ifu_rdt,
  // load/store bus
  input  wire logic                    lsu_vld,
  input  wire logic                    lsu_rdy,
  input  wire logic                    lsu_wen,
  input  wire logic [`TRACE_XLEN-1:0]  lsu_adr,
  input  wire logic [`TRACE_XLEN-1:0]  lsu_wdt,
  input  wire logic [`TRACE_XLEN-1:0]  lsu_rdt,
  // GPR write port
  input  wire logic                    gpr_wen,
  input  wire logic [`TRACE_GLOG-1:0]  gpr_wid,
  input  wire logic [`TRACE_XLEN-1:0]  gpr_wdt,
  // trace record
  output logic                         trace_vld,
  output logic      [`TRACE_XLEN-1:0]  trace_pc,
  output logic      [`TRACE_XLEN-1:0]  trace_ins,
  output logic                         trace_rvc,
  output logic                         trace_gpr_vld,
  output logic      [`TRACE_GLOG-1:0]  trace_gpr_idx,
  output logic      [`TRACE_XLEN-1:0]  trace_gpr_dat,
  output trace_pkg::mem_kind_t         trace_mem,
  output logic      [`TRACE_XLEN-1:0]  trace_mem_adr,
  output logic      [`TRACE_XLEN-1:0]  trace_mem_dat,
  // statistics
  output logic      [`TRACE_CNT_W-1:0] cnt_ret,
  output logic      [`TRACE_CNT_W-1:0] cnt_ld,
  output logic      [`TRACE_CNT_W-1:0] cnt_st,
  output logic      [`TRACE_CNT_W-1:0] cnt_rvc
);

  import trace_pkg::*;

  // fetched instruction, two cycles after the fetch transfer
  logic                   fet_vld;
  logic [`TRACE_XLEN-1:0] fet_pc;
  logic [`TRACE_XLEN-1:0] fet_ins;
  logic                   fet_rvc;

  // memory event, two cycles after the load/store transfer
  logic                   mem_vld;
  mem_kind_t              mem_kind;
  logic [`TRACE_XLEN-1:0] mem_adr;
  logic [`TRACE_XLEN-1:0] mem_dat;

  ////////////////////
  // bus capture
  ////////////////////

  trace_fetch_capture u_fetch (
    .tcb_ifu (tcb_ifu),
    .reset   (reset),
    .ifu_vld (ifu_vld),
    .ifu_rdy (ifu_rdy),
    .ifu_adr (ifu_adr),
    .ifu_rdt (ifu_rdt),
    .fet_vld (fet_vld),
    .fet_pc  (fet_pc),
    .fet_ins (fet_ins),
    .fet_rvc (fet_rvc)
  );

  trace_lsu_capture u_lsu (
    .tcb_ifu  (tcb_ifu),
    .reset    (reset),
    .lsu_vld  (lsu_vld),
    .lsu_rdy  (lsu_rdy),
    .lsu_wen  (lsu_wen),
    .lsu_adr  (lsu_adr),
    .lsu_wdt  (lsu_wdt),
    .lsu_rdt  (lsu_rdt),
    .mem_vld  (mem_vld),
    .mem_kind (mem_kind),
    .mem_adr  (mem_adr),
    .mem_dat  (mem_dat)
  );

  ////////////////////
  // record and statistics
  ////////////////////

  // GPR port needs no capture, writes are seen in the cycle they happen
  trace_record_assembler u_asm (
    .tcb_ifu       (tcb_ifu),
    .reset         (reset),
    .fet_vld       (fet_vld),
    .fet_pc        (fet_pc),
    .fet_ins       (fet_ins),
    .fet_rvc       (fet_rvc),
    .mem_vld       (mem_vld),
    .mem_kind      (mem_kind),
    .mem_adr       (mem_adr),
    .mem_dat       (mem_dat),
    .gpr_wen       (gpr_wen),
    .gpr_wid       (gpr_wid),
    .gpr_wdt       (gpr_wdt),
    .trace_vld     (trace_vld),
    .trace_pc      (trace_pc),
    .trace_ins     (trace_ins),
    .trace_rvc     (trace_rvc),
    .trace_gpr_vld (trace_gpr_vld),
    .trace_gpr_idx (trace_gpr_idx),
    .trace_gpr_dat (trace_gpr_dat),
    .trace_mem     (trace_mem),
    .trace_mem_adr (trace_mem_adr),
    .trace_mem_dat (trace_mem_dat)
  );

  trace_stats u_stats (
    .tcb_ifu   (tcb_ifu),
    .reset     (reset),
    .trace_vld (trace_vld),
    .trace_mem (trace_mem),
    .trace_rvc (trace_rvc),
    .cnt_ret   (cnt_ret),
    .cnt_ld    (cnt_ld),
    .cnt_st    (cnt_st),
    .cnt_rvc   (cnt_rvc)
  );

endmodule: trace_unit

`default_nettype wire

//--- tb/trace_unit_props.sv
// timing assertions of the trace record assembler
// bound into the assembler from the testbench

`timescale 1ns/1ns
`default_nettype none

module trace_unit_props (
  input wire logic                  tcb_ifu,
  input wire logic                  reset,
  input wire trace_pkg::asm_state_t state,
  input wire logic                  fet_vld,
  input wire logic                  trace_vld
);

  import trace_pkg::*;

  ////////////////////
  // FSM
  ////////////////////

  // nothing to emit before the first instruction
  no_record_when_idle: assert property (
    @(posedge tcb_ifu) disable iff (reset)
    (state == asm_idle) |-> !trace_vld
  ) else $error("trace_vld is high while the assembler is idle");

  ////////////////////
  // record timing
  ////////////////////

  // record leaves one cycle after the next fetch strobe
  record_after_fetch: assert property (
    @(posedge tcb_ifu) disable iff (reset)
    (fet_vld && state == asm_active) |=> trace_vld
  ) else $error("no trace record one cycle after a fetch in the active state");

  // and at no other time
  record_only_after_fetch: assert property (
    @(posedge tcb_ifu) disable iff (reset)
    !(fet_vld && state == asm_active) |=> !trace_vld
  ) else $error("trace record emitted without a preceding fetch");

  strobes_known: assert property (
    @(posedge tcb_ifu) disable iff (reset)
    !$isunknown({fet_vld, trace_vld})
  ) else $error("fetch or trace strobe is unknown");

endmodule: trace_unit_props

`default_nettype wire

//--- tb/trace_unit_tb.sv
// testbench of the trace unit, drives fetch, load/store and GPR ports from an LFSR
// a queue model of the expected records is checked against every trace strobe

`timescale 1ns/1ns
`default_nettype none
`include "trace_defs.svh"

module trace_unit_tb;

  import trace_pkg::*;

  // fetches of the directed tests, the random test and the burst
  localparam int n_directed = 10;
  localparam int n_random   = 40;
  localparam int n_burst    = 8;
  // worst case cycles of one instruction step with both buses stalled
  localparam int step_cycles = 14;
  // reset, instruction steps and a drain of a few cycles per test
  localparam int stim_cycles =
    4 + (n_directed + n_random + n_burst) * step_cycles + 6 * 4;
  localparam int cycle_limit = stim_cycles * 3 / 2;

  // one expected trace record
  typedef struct packed {
    logic [`TRACE_XLEN-1:0] pc;
    logic [`TRACE_XLEN-1:0] ins;
    logic                   rvc;
    logic                   gpr_vld;
    logic [`TRACE_GLOG-1:0] gpr_idx;
    logic [`TRACE_XLEN-1:0] gpr_dat;
    mem_kind_t              mem;
    logic [`TRACE_XLEN-1:0] mem_adr;
    logic [`TRACE_XLEN-1:0] mem_dat;
  } rec_t;

  logic                    tcb_ifu;
  logic                    reset;
  logic                    ifu_vld;
  logic                    ifu_rdy;
  logic [`TRACE_XLEN-1:0]  ifu_adr;
  logic [`TRACE_XLEN-1:0]  ifu_rdt;
  logic                    lsu_vld;
  logic                    lsu_rdy;
  logic                    lsu_wen;
  logic [`TRACE_XLEN-1:0]  lsu_adr;
  logic [`TRACE_XLEN-1:0]  lsu_wdt;
  logic [`TRACE_XLEN-1:0]  lsu_rdt;
  logic                    gpr_wen;
  logic [`TRACE_GLOG-1:0]  gpr_wid;
  logic [`TRACE_XLEN-1:0]  gpr_wdt;
  logic                    trace_vld;
  logic [`TRACE_XLEN-1:0]  trace_pc;
  logic [`TRACE_XLEN-1:0]  trace_ins;
  logic                    trace_rvc;
  logic                    trace_gpr_vld;
  logic [`TRACE_GLOG-1:0]  trace_gpr_idx;
  logic [`TRACE_XLEN-1:0]  trace_gpr_dat;
  mem_kind_t               trace_mem;
  logic [`TRACE_XLEN-1:0]  trace_mem_adr;
  logic [`TRACE_XLEN-1:0]  trace_mem_dat;
  logic [`TRACE_CNT_W-1:0] cnt_ret;
  logic [`TRACE_CNT_W-1:0] cnt_ld;
  logic [`TRACE_CNT_W-1:0] cnt_st;
  logic [`TRACE_CNT_W-1:0] cnt_rvc;

  // model state
  logic [31:0] lfsr;
  rec_t        rec_q[$];
  string       name_q[$];
  int          fetch_q[$];
  rec_t        cur;
  string       cur_name;
  logic        have_cur = 1'b0;
  logic        seen_fetch = 1'b0;
  int          exp_ret = 0;
  int          exp_ld = 0;
  int          exp_st = 0;
  int          exp_rvc = 0;
  // bookkeeping
  int          cycle = 0;
  int          errors = 0;
  int          n_checks = 0;
  int          tests_run = 0;
  int          test_err = 0;
  string       cur_test = "reset";

  trace_unit dut (.*);

  bind trace_record_assembler trace_unit_props u_props (
    .tcb_ifu   (tcb_ifu),
    .reset     (reset),
    .state     (state),
    .fet_vld   (fet_vld),
    .trace_vld (trace_vld)
  );

  initial begin
    tcb_ifu = 1'b0;
    forever #2 tcb_ifu = ~tcb_ifu;
  end

  ////////////////////
  // model helpers
  ////////////////////

  // galois LFSR, one step per bit taken
  function automatic logic [31:0] draw(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return val;
  endfunction

  // previous instruction is complete once the next one is fetched
  task automatic new_instr(input logic [31:0] adr, input logic [31:0] word);
    if (have_cur) begin
      rec_q.push_back(cur);
      name_q.push_back(cur_name);
      exp_ret++;
      exp_ld  += (cur.mem == mem_load);
      exp_st  += (cur.mem == mem_store);
      exp_rvc += cur.rvc;
    end
    cur     = '0;
    cur.pc  = adr;
    // compressed unless both low bits are set, upper half then reads zero
    cur.rvc = (word[1:0] != 2'b11);
    cur.ins = cur.rvc ? {16'h0000, word[15:0]} : word;
    cur.mem = mem_none;
    cur_name = cur_test;
    have_cur = 1'b1;
  endtask

  task automatic check_val(input string name, input string field,
                           input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    assert (act === exp) else begin
      $display("FAILED %s %s expected %h actual %h", name, field, exp, act);
      errors++;
    end
  endtask

  ////////////////////
  // bus drivers
  ////////////////////

  // fetch transfer after stall cycles of ifu_rdy low, word returned a cycle later
  task automatic fetch(input logic [31:0] adr, input logic [31:0] word, input int stall);
    @(negedge tcb_ifu);
    ifu_vld = 1'b1;
    ifu_adr = adr;
    ifu_rdy = 1'b0;
    repeat (stall) @(negedge tcb_ifu);
    ifu_rdy = 1'b1;
    new_instr(adr, word);
    @(negedge tcb_ifu);
    ifu_vld = 1'b0;
    ifu_rdy = draw(1);
    ifu_rdt = word;
    // GPR writes from here on land after the new fet_vld
    @(negedge tcb_ifu);
  endtask

  // one fetch transfer per cycle, each response overlaps the next request
  task automatic fetch_burst(input int n, input logic [31:0] base);
    logic [31:0] word;
    logic [31:0] adr;
    word = '0;
    for (int k = 0; k < n; k++) begin
      @(negedge tcb_ifu);
      adr     = base + 4 * k;
      ifu_vld = 1'b1;
      ifu_rdy = 1'b1;
      ifu_adr = adr;
      ifu_rdt = word;
      word    = draw(32);
      new_instr(adr, word);
    end
    @(negedge tcb_ifu);
    ifu_vld = 1'b0;
    ifu_rdt = word;
    @(negedge tcb_ifu);
  endtask

  task automatic gpr_write(input logic [4:0] idx, input logic [31:0] dat);
    @(negedge tcb_ifu);
    gpr_wen = 1'b1;
    gpr_wid = idx;
    gpr_wdt = dat;
    // x0 is never traced
    if (idx != 5'd0) begin
      cur.gpr_vld = 1'b1;
      cur.gpr_idx = idx;
      cur.gpr_dat = dat;
    end
    @(negedge tcb_ifu);
    gpr_wen = 1'b0;
  endtask

  task automatic lsu_access(input logic wen, input logic [31:0] adr, input logic [31:0] wdt,
                            input logic [31:0] rdt, input int stall);
    @(negedge tcb_ifu);
    lsu_vld = 1'b1;
    lsu_wen = wen;
    lsu_adr = adr;
    lsu_wdt = wdt;
    lsu_rdy = 1'b0;
    repeat (stall) @(negedge tcb_ifu);
    lsu_rdy     = 1'b1;
    cur.mem     = wen ? mem_store : mem_load;
    cur.mem_adr = adr;
    cur.mem_dat = wen ? wdt : rdt;
    @(negedge tcb_ifu);
    lsu_vld = 1'b0;
    lsu_rdy = draw(1);
    lsu_rdt = rdt;
  endtask

  ////////////////////
  // scoreboard
  ////////////////////

  task automatic check_record();
    rec_t  exp;
    string name;
    int    t_fetch;
    if (rec_q.size() == 0 || fetch_q.size() == 0) begin
      $display("trace record at cycle %0d with no instruction waiting for it", cycle);
      errors++;
    end else begin
      exp     = rec_q.pop_front();
      name    = name_q.pop_front();
      t_fetch = fetch_q.pop_front();
      check_val(name, "latency", t_fetch + 3, cycle);
      check_val(name, "pc", exp.pc, trace_pc);
      check_val(name, "ins", exp.ins, trace_ins);
      check_val(name, "rvc", exp.rvc, trace_rvc);
      check_val(name, "gpr_vld", exp.gpr_vld, trace_gpr_vld);
      if (exp.gpr_vld) begin
        check_val(name, "gpr_idx", exp.gpr_idx, trace_gpr_idx);
        check_val(name, "gpr_dat", exp.gpr_dat, trace_gpr_dat);
      end
      check_val(name, "mem", exp.mem, trace_mem);
      if (exp.mem != mem_none) begin
        check_val(name, "mem_adr", exp.mem_adr, trace_mem_adr);
        check_val(name, "mem_dat", exp.mem_dat, trace_mem_dat);
      end
    end
  endtask

  // values read here were stable through the cycle before the edge
  always @(posedge tcb_ifu) begin
    cycle = cycle + 1;
    if (reset) begin
      seen_fetch = 1'b0;
    end else begin
      // transfer times of every fetch after the first, each releases a record
      if (ifu_vld && ifu_rdy) begin
        if (seen_fetch) begin
          fetch_q.push_back(cycle);
        end
        seen_fetch = 1'b1;
      end
      if (trace_vld) begin
        check_record();
      end
    end
  end

  initial begin
    repeat (cycle_limit) @(posedge tcb_ifu);
    $display("timeout, the run did not finish within %0d cycles", cycle_limit);
    $display("Some tests failed");
    $finish;
  end

  ////////////////////
  // tests
  ////////////////////

  task automatic start_test(input string name);
    cur_test = name;
    test_err = errors;
  endtask

  // records still in flight leave before a test closes
  task automatic drain_records();
    while (rec_q.size() != 0) begin
      @(negedge tcb_ifu);
    end
  endtask

  // last instruction of a test stays open until the next fetch
  task automatic end_test();
    drain_records();
    tests_run++;
    $display("test %s finished with %0d errors", cur_test, errors - test_err);
  endtask

  initial begin
    logic [31:0] word;
    lfsr    = 32'hc8b4;
    reset   = 1'b1;
    ifu_vld = 1'b0;
    ifu_rdy = 1'b0;
    ifu_adr = '0;
    ifu_rdt = '0;
    lsu_vld = 1'b0;
    lsu_rdy = 1'b0;
    lsu_wen = 1'b0;
    lsu_adr = '0;
    lsu_wdt = '0;
    lsu_rdt = '0;
    gpr_wen = 1'b0;
    gpr_wid = '0;
    gpr_wdt = '0;
    repeat (3) @(posedge tcb_ifu);
    @(negedge tcb_ifu);
    reset = 1'b0;

    // first fetch opens the first instruction only
    start_test("first_fetch_and_size");
    fetch(32'h0000_1000, 32'h0051_0093, 0);
    fetch(32'h0000_1004, 32'hdead_4505, 1);
    end_test();

    start_test("gpr_write");
    fetch(32'h0000_1006, 32'h0020_8133, 0);
    gpr_write(5'd2, 32'h1234_5678);
    fetch(32'h0000_100a, 32'h0000_0013, 0);
    gpr_write(5'd0, 32'hffff_ffff);
    end_test();

    start_test("load_store");
    fetch(32'h0000_100e, 32'h0041_2183, 2);
    lsu_access(1'b0, 32'h0000_8004, 32'h0bad_0bad, 32'hcafe_f00d, 1);
    fetch(32'h0000_1012, 32'h0031_2423, 0);
    lsu_access(1'b1, 32'h0000_8008, 32'h8765_4321, 32'h5555_aaaa, 0);
    end_test();

    // held off fetches, then one transfer per cycle
    start_test("stall_and_burst");
    fetch(32'h0000_1016, 32'h0000_0073, 3);
    fetch_burst(n_burst, 32'h0000_1100);
    end_test();

    start_test("random");
    for (int k = 0; k < n_random; k++) begin
      word = draw(32);
      fetch(32'h0000_2000 + 4 * k, word, draw(2));
      if (draw(1)) begin
        gpr_write(draw(5), draw(32));
      end
      if (draw(1)) begin
        lsu_access(draw(1), draw(32), draw(32), draw(32), draw(2));
      end
    end
    end_test();

    // one more fetch releases the last random record
    start_test("counters");
    fetch(32'h0000_3000, 32'h0000_0001, 0);
    drain_records();
    check_val("counters", "cnt_ret", exp_ret, cnt_ret);
    check_val("counters", "cnt_ld", exp_ld, cnt_ld);
    check_val("counters", "cnt_st", exp_st, cnt_st);
    check_val("counters", "cnt_rvc", exp_rvc, cnt_rvc);
    end_test();

    $display("%0d tests, %0d checks, %0d errors", tests_run, n_checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule: trace_unit_tb

`default_nettype wire

//--- vlog.f
+incdir+hdl
hdl/trace_pkg.sv
hdl/trace_fetch_capture.sv
hdl/trace_lsu_capture.sv
hdl/trace_record_assembler.sv
hdl/trace_stats.sv
hdl/trace_unit.sv
tb/trace_unit_props.sv
tb/trace_unit_tb.sv
